/* Bender.yml */
package:
  name: axi_lite_async_fifo

sources:
  - files:
      - hdl/afifo_pkg.sv
      - hdl/fifo_push_if.sv
      - hdl/gray_ptr_sync.sv
      - hdl/fifo_wr_ctrl.sv
      - hdl/fifo_rd_ctrl.sv
      - hdl/dual_clock_ram.sv
      - hdl/axi_lite_wr_slave.sv
      - hdl/axi_lite_rd_slave.sv
      - hdl/axi_lite_async_fifo.sv
  - target: simulation
    files:
      - tb/tb_axi_lite_async_fifo.sv

/* hdl/afifo_pkg.sv */
package afifo_pkg;

    // ------------------------------
    // widths and depth
    // ------------------------------
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 4;
    localparam int FIFO_DEPTH = 8;
    // address bits into the ram, depth must stay a power of two
    localparam int PTR_WIDTH  = $clog2(FIFO_DEPTH);

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [PTR_WIDTH-1:0]  ram_addr_t;
    // one extra msb so full and empty differ
    typedef logic [PTR_WIDTH:0]    ptr_t;

    // ------------------------------
    // axi responses and register map
    // ------------------------------
    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    localparam addr_t ADDR_STATUS = 4'h0;
    localparam addr_t ADDR_PEEK   = 4'h4;

    // status word field positions
    localparam int STAT_EMPTY_BIT = 0;
    localparam int STAT_FULL_BIT  = 1;
    // occupancy is PTR_WIDTH+1 bits wide from here
    localparam int STAT_OCC_LSB   = 8;

    // ------------------------------
    // gray code helpers
    // ------------------------------
    function automatic ptr_t bin2gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray2bin(ptr_t gray);
        ptr_t bin;
        bin[PTR_WIDTH] = gray[PTR_WIDTH];
        // each bit folds in every gray bit above it
        for (int i = PTR_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

/* hdl/axi_lite_async_fifo.sv */
`timescale 1ns/1ns

module axi_lite_async_fifo (
    input  logic             clk_axi,
    input  logic             clk_periph,
    input  logic             axi_resetn_i,
    // AW
    input  logic             axi_awvalid_i,
    output logic             axi_awready_o,
    // W
    input  afifo_pkg::data_t axi_wdata_i,
    input  logic             axi_wvalid_i,
    output logic             axi_wready_o,
    // B
    output afifo_pkg::resp_t axi_bresp_o,
    output logic             axi_bvalid_o,
    input  logic             axi_bready_i,
    // AR
    input  afifo_pkg::addr_t axi_araddr_i,
    input  logic             axi_arvalid_i,
    output logic             axi_arready_o,
    // R
    output afifo_pkg::data_t axi_rdata_o,
    output afifo_pkg::resp_t axi_rresp_o,
    output logic             axi_rvalid_o,
    input  logic             axi_rready_i,
    // peripheral side, clk_periph domain except full
    input  logic             periph_rd_en_i,
    output afifo_pkg::data_t periph_rdata_o,
    output logic             periph_rvalid_o,
    output logic             periph_empty_o,
    output logic             periph_full_o
);

    // ------------------------------
    // internal nets
    // ------------------------------
    fifo_push_if push_bus ();

    logic                 ram_we;
    afifo_pkg::ram_addr_t ram_waddr;
    afifo_pkg::data_t     ram_wdata;
    afifo_pkg::ram_addr_t ram_peek_addr;
    afifo_pkg::data_t     ram_peek_data;
    afifo_pkg::ram_addr_t ram_raddr;
    afifo_pkg::data_t     ram_rdata;
    // gray pointers leaving each domain, binary after sync
    afifo_pkg::ptr_t      wr_gray;
    afifo_pkg::ptr_t      wr_bin_sync;
    afifo_pkg::ptr_t      rd_gray;
    afifo_pkg::ptr_t      rd_bin_sync;

    axi_lite_wr_slave u_wr_slave (
        .clk_axi       (clk_axi),
        .axi_resetn_i  (axi_resetn_i),
        .axi_awvalid_i (axi_awvalid_i),
        .axi_awready_o (axi_awready_o),
        .axi_wdata_i   (axi_wdata_i),
        .axi_wvalid_i  (axi_wvalid_i),
        .axi_wready_o  (axi_wready_o),
        .axi_bresp_o   (axi_bresp_o),
        .axi_bvalid_o  (axi_bvalid_o),
        .axi_bready_i  (axi_bready_i),
        .push_o        (push_bus.wr_slave)
    );

    axi_lite_rd_slave u_rd_slave (
        .clk_axi       (clk_axi),
        .axi_resetn_i  (axi_resetn_i),
        .axi_araddr_i  (axi_araddr_i),
        .axi_arvalid_i (axi_arvalid_i),
        .axi_arready_o (axi_arready_o),
        .axi_rdata_o   (axi_rdata_o),
        .axi_rresp_o   (axi_rresp_o),
        .axi_rvalid_o  (axi_rvalid_o),
        .axi_rready_i  (axi_rready_i),
        .stat_i        (push_bus.rd_slave)
    );

    fifo_wr_ctrl u_wr_ctrl (
        .clk_axi         (clk_axi),
        .axi_resetn_i    (axi_resetn_i),
        .push_i          (push_bus.ctrl),
        .ram_we_o        (ram_we),
        .ram_waddr_o     (ram_waddr),
        .ram_wdata_o     (ram_wdata),
        .ram_peek_addr_o (ram_peek_addr),
        .ram_peek_data_i (ram_peek_data),
        .wr_gray_o       (wr_gray),
        .rd_bin_i        (rd_bin_sync),
        .full_o          (periph_full_o)
    );

    fifo_rd_ctrl u_rd_ctrl (
        .clk_periph   (clk_periph),
        .axi_resetn_i (axi_resetn_i),
        .rd_en_i      (periph_rd_en_i),
        .rdata_o      (periph_rdata_o),
        .rvalid_o     (periph_rvalid_o),
        .empty_o      (periph_empty_o),
        .ram_raddr_o  (ram_raddr),
        .ram_rdata_i  (ram_rdata),
        .rd_gray_o    (rd_gray),
        .wr_bin_i     (wr_bin_sync)
    );

    dual_clock_ram u_ram (
        .clk_axi     (clk_axi),
        .we_i        (ram_we),
        .waddr_i     (ram_waddr),
        .wdata_i     (ram_wdata),
        .peek_addr_i (ram_peek_addr),
        .peek_data_o (ram_peek_data),
        .raddr_i     (ram_raddr),
        .rdata_o     (ram_rdata)
    );

    // write pointer into the peripheral domain
    gray_ptr_sync u_wr_sync (
        .clk_i        (clk_periph),
        .axi_resetn_i (axi_resetn_i),
        .gray_i       (wr_gray),
        .bin_o        (wr_bin_sync)
    );

    // read pointer back into the axi domain
    gray_ptr_sync u_rd_sync (
        .clk_i        (clk_axi),
        .axi_resetn_i (axi_resetn_i),
        .gray_i       (rd_gray),
        .bin_o        (rd_bin_sync)
    );

endmodule

/* hdl/axi_lite_rd_slave.sv */
`timescale 1ns/1ns

module axi_lite_rd_slave (
    input  logic             clk_axi,
    input  logic             axi_resetn_i,
    input  afifo_pkg::addr_t axi_araddr_i,
    input  logic             axi_arvalid_i,
    output logic             axi_arready_o,
    output afifo_pkg::data_t axi_rdata_o,
    output afifo_pkg::resp_t axi_rresp_o,
    output logic             axi_rvalid_o,
    input  logic             axi_rready_i,
    fifo_push_if.rd_slave    stat_i
);

    logic             ar_hs;
    logic             rvalid_d;
    afifo_pkg::data_t status_word;

    assign ar_hs    = axi_arvalid_i && axi_arready_o;
    assign rvalid_d = ar_hs || (axi_rvalid_o && !axi_rready_i);

    // status word assembled from the registered flags
    always_comb begin
        status_word = '0;
        status_word[afifo_pkg::STAT_EMPTY_BIT] = stat_i.empty;
        status_word[afifo_pkg::STAT_FULL_BIT]  = stat_i.full;
        status_word[afifo_pkg::STAT_OCC_LSB +: afifo_pkg::PTR_WIDTH+1] = stat_i.occupancy;
    end

    // arready mirrors rvalid, one read in flight at most
    always_ff @(posedge clk_axi or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            axi_arready_o <= 1'b0;
            axi_rvalid_o  <= 1'b0;
        end else begin
            axi_arready_o <= !rvalid_d;
            axi_rvalid_o  <= rvalid_d;
        end
    end

    // ------------------------------
    // address decode
    // ------------------------------
    always_ff @(posedge clk_axi) begin
        if (ar_hs) begin
            if (axi_araddr_i == afifo_pkg::ADDR_STATUS) begin
                axi_rdata_o <= status_word;
                axi_rresp_o <= afifo_pkg::RESP_OKAY;
            end else if (axi_araddr_i == afifo_pkg::ADDR_PEEK && !stat_i.empty) begin
                // head word stays in the fifo
                axi_rdata_o <= stat_i.peek_data;
                axi_rresp_o <= afifo_pkg::RESP_OKAY;
            end else begin
                // empty peek or unmapped address
                axi_rdata_o <= '0;
                axi_rresp_o <= afifo_pkg::RESP_SLVERR;
            end
        end
    end

endmodule

/* hdl/axi_lite_wr_slave.sv */
`timescale 1ns/1ns

module axi_lite_wr_slave (
    input  logic               clk_axi,
    input  logic               axi_resetn_i,
    input  logic               axi_awvalid_i,
    output logic               axi_awready_o,
    input  afifo_pkg::data_t   axi_wdata_i,
    input  logic               axi_wvalid_i,
    output logic               axi_wready_o,
    output afifo_pkg::resp_t   axi_bresp_o,
    output logic               axi_bvalid_o,
    input  logic               axi_bready_i,
    fifo_push_if.wr_slave      push_o
);

    logic             aw_pend_q;
    logic             w_pend_q;
    afifo_pkg::data_t wdata_q;

    logic aw_hs;
    logic w_hs;
    logic do_write;
    logic aw_pend_d;
    logic w_pend_d;
    logic bvalid_d;

    // ------------------------------
    // handshake and capture logic
    // ------------------------------
    assign aw_hs = axi_awvalid_i && axi_awready_o;
    assign w_hs  = axi_wvalid_i && axi_wready_o;

    // both halves present, either captured earlier or arriving now
    assign do_write = (aw_pend_q || aw_hs) && (w_pend_q || w_hs);

    always_comb begin
        aw_pend_d = (aw_pend_q || aw_hs) && !do_write;
        w_pend_d  = (w_pend_q || w_hs) && !do_write;
        // response held until the master takes it
        bvalid_d  = do_write || (axi_bvalid_o && !axi_bready_i);
    end

    always_ff @(posedge clk_axi or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            aw_pend_q     <= 1'b0;
            w_pend_q      <= 1'b0;
            axi_awready_o <= 1'b0;
            axi_wready_o  <= 1'b0;
            axi_bvalid_o  <= 1'b0;
            axi_bresp_o   <= afifo_pkg::RESP_OKAY;
        end else begin
            aw_pend_q     <= aw_pend_d;
            w_pend_q      <= w_pend_d;
            // a channel closes once captured or while B is outstanding
            axi_awready_o <= !aw_pend_d && !bvalid_d;
            axi_wready_o  <= !w_pend_d && !bvalid_d;
            axi_bvalid_o  <= bvalid_d;
            if (do_write) begin
                axi_bresp_o <= push_o.full ? afifo_pkg::RESP_SLVERR : afifo_pkg::RESP_OKAY;
            end
        end
    end

    // W data held when it beats AW
    always_ff @(posedge clk_axi) begin
        if (w_hs && !do_write) begin
            wdata_q <= axi_wdata_i;
        end
    end

    // ------------------------------
    // push towards the fifo
    // ------------------------------
    // data is dropped when full, the response carries SLVERR
    assign push_o.push_req  = do_write && !push_o.full;
    assign push_o.push_data = w_pend_q ? wdata_q : axi_wdata_i;

    // response stays up and unchanged until the master takes it
    bvalid_hold_a : assert property (
        @(posedge clk_axi) disable iff (!axi_resetn_i)
        axi_bvalid_o && !axi_bready_i |=> axi_bvalid_o && $stable(axi_bresp_o)
    );

endmodule

/* hdl/dual_clock_ram.sv */
`timescale 1ns/1ns

module dual_clock_ram (
    input  logic                 clk_axi,
    input  logic                 we_i,
    input  afifo_pkg::ram_addr_t waddr_i,
    input  afifo_pkg::data_t     wdata_i,
    input  afifo_pkg::ram_addr_t peek_addr_i,
    output afifo_pkg::data_t     peek_data_o,
    input  afifo_pkg::ram_addr_t raddr_i,
    output afifo_pkg::data_t     rdata_o
);

    afifo_pkg::data_t mem [afifo_pkg::FIFO_DEPTH];

    // single write port in the axi domain
    always_ff @(posedge clk_axi) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // peek port, read from the axi side
    assign peek_data_o = mem[peek_addr_i];
    // pop port, read from the peripheral side
    assign rdata_o     = mem[raddr_i];

endmodule

/* hdl/fifo_push_if.sv */
`timescale 1ns/1ns

interface fifo_push_if;

    // one-cycle push pulse with its word, no back-pressure
    logic             push_req;
    afifo_pkg::data_t push_data;

    // registered status from the write-side controller
    logic             full;
    logic             empty;
    afifo_pkg::ptr_t  occupancy;

    // word at the synchronized read pointer
    afifo_pkg::data_t peek_data;

    // write slave only pushes while full is low
    modport wr_slave (
        output push_req,
        output push_data,
        input  full
    );

    modport ctrl (
        input  push_req,
        input  push_data,
        output full,
        output empty,
        output occupancy,
        output peek_data
    );

    modport rd_slave (
        input full,
        input empty,
        input occupancy,
        input peek_data
    );

endinterface

/* hdl/fifo_rd_ctrl.sv */
`timescale 1ns/1ns

module fifo_rd_ctrl (
    input  logic                 clk_periph,
    input  logic                 axi_resetn_i,
    input  logic                 rd_en_i,
    output afifo_pkg::data_t     rdata_o,
    output logic                 rvalid_o,
    output logic                 empty_o,
    output afifo_pkg::ram_addr_t ram_raddr_o,
    input  afifo_pkg::data_t     ram_rdata_i,
    output afifo_pkg::ptr_t      rd_gray_o,
    input  afifo_pkg::ptr_t      wr_bin_i
);

    afifo_pkg::ptr_t rd_bin_q;
    afifo_pkg::ptr_t rd_gray_q;
    afifo_pkg::ptr_t rd_bin_d;
    logic            pop;

    // empty against the synchronized write pointer
    assign empty_o  = (rd_bin_q == wr_bin_i);
    // enable is ignored while empty
    assign pop      = rd_en_i && !empty_o;
    assign rd_bin_d = rd_bin_q + {{afifo_pkg::PTR_WIDTH{1'b0}}, pop};

    always_ff @(posedge clk_periph or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
            rvalid_o  <= 1'b0;
        end else begin
            rd_bin_q  <= rd_bin_d;
            rd_gray_q <= afifo_pkg::bin2gray(rd_bin_d);
            // single-cycle valid per popped word
            rvalid_o  <= pop;
        end
    end

    // head word, only meaningful with rvalid
    always_ff @(posedge clk_periph) begin
        if (pop) begin
            rdata_o <= ram_rdata_i;
        end
    end

    assign ram_raddr_o = rd_bin_q[afifo_pkg::PTR_WIDTH-1:0];
    assign rd_gray_o   = rd_gray_q;

    // a pop while empty would carry the read pointer past the write pointer
    no_pop_when_empty_a : assert property (
        @(posedge clk_periph) disable iff (!axi_resetn_i)
        afifo_pkg::ptr_t'(wr_bin_i - rd_bin_q) <= afifo_pkg::FIFO_DEPTH
    );

endmodule

/* hdl/fifo_wr_ctrl.sv */
`timescale 1ns/1ns

module fifo_wr_ctrl (
    input  logic                 clk_axi,
    input  logic                 axi_resetn_i,
    fifo_push_if.ctrl            push_i,
    output logic                 ram_we_o,
    output afifo_pkg::ram_addr_t ram_waddr_o,
    output afifo_pkg::data_t     ram_wdata_o,
    output afifo_pkg::ram_addr_t ram_peek_addr_o,
    input  afifo_pkg::data_t     ram_peek_data_i,
    output afifo_pkg::ptr_t      wr_gray_o,
    input  afifo_pkg::ptr_t      rd_bin_i,
    output logic                 full_o
);

    afifo_pkg::ptr_t wr_bin_q;
    afifo_pkg::ptr_t wr_gray_q;
    afifo_pkg::ptr_t wr_bin_d;
    // read pointer as seen one cycle ago, shared by status and peek
    afifo_pkg::ptr_t rd_bin_q;
    afifo_pkg::ptr_t occ_d;
    afifo_pkg::ptr_t occ_q;
    logic            full_q;
    logic            empty_q;

    // ------------------------------
    // pointer and status update
    // ------------------------------
    assign wr_bin_d = wr_bin_q + {{afifo_pkg::PTR_WIDTH{1'b0}}, push_i.push_req};
    // modulo difference, msb set only at exactly FIFO_DEPTH words
    assign occ_d    = wr_bin_d - rd_bin_i;

    always_ff @(posedge clk_axi or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
            rd_bin_q  <= '0;
            occ_q     <= '0;
            full_q    <= 1'b0;
            empty_q   <= 1'b1;
        end else begin
            wr_bin_q  <= wr_bin_d;
            wr_gray_q <= afifo_pkg::bin2gray(wr_bin_d);
            rd_bin_q  <= rd_bin_i;
            occ_q     <= occ_d;
            full_q    <= occ_d[afifo_pkg::PTR_WIDTH];
            empty_q   <= (occ_d == '0);
        end
    end

    // ------------------------------
    // ram ports and status out
    // ------------------------------
    // every pulse is a write, the slave already checked full
    assign ram_we_o        = push_i.push_req;
    assign ram_waddr_o     = wr_bin_q[afifo_pkg::PTR_WIDTH-1:0];
    assign ram_wdata_o     = push_i.push_data;
    assign ram_peek_addr_o = rd_bin_q[afifo_pkg::PTR_WIDTH-1:0];
    assign wr_gray_o       = wr_gray_q;
    assign full_o          = full_q;

    assign push_i.full      = full_q;
    assign push_i.empty     = empty_q;
    assign push_i.occupancy = occ_q;
    assign push_i.peek_data = ram_peek_data_i;

    // a push into a full fifo would overwrite the head word
    push_never_full_a : assert property (
        @(posedge clk_axi) disable iff (!axi_resetn_i)
        push_i.push_req |-> !full_q
    );

endmodule

/* hdl/gray_ptr_sync.sv */
`timescale 1ns/1ns

module gray_ptr_sync (
    input  logic            clk_i,
    input  logic            axi_resetn_i,
    input  afifo_pkg::ptr_t gray_i,
    output afifo_pkg::ptr_t bin_o
);

    // first stage may go metastable, second one settles
    afifo_pkg::ptr_t sync1_q;
    afifo_pkg::ptr_t sync2_q;

    always_ff @(posedge clk_i or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gray_i;
            sync2_q <= sync1_q;
        end
    end

    // only one gray bit flips per step, so the sampled value is
    // always either the old or the new pointer
    assign bin_o = afifo_pkg::gray2bin(sync2_q);

endmodule

/* sim.f */
hdl/afifo_pkg.sv
hdl/fifo_push_if.sv
hdl/gray_ptr_sync.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/dual_clock_ram.sv
hdl/axi_lite_wr_slave.sv
hdl/axi_lite_rd_slave.sv
hdl/axi_lite_async_fifo.sv
tb/tb_axi_lite_async_fifo.sv

/* tb/tb_axi_lite_async_fifo.sv */
`timescale 1ns/1ns

module tb_axi_lite_async_fifo;

    localparam int AXI_PERIOD    = 8;
    localparam int PERIPH_PERIOD = 14;
    // cycles allowed for any single handshake
    localparam int HS_LIMIT      = 50;

    typedef enum logic [1:0] {OP_AXI_WRITE, OP_AXI_READ, OP_PERIPH_POP, OP_SETTLE} op_e;
    // AW/W ordering of a write, random picks one of the other three
    typedef enum logic [1:0] {ORD_RANDOM, ORD_AW_FIRST, ORD_W_FIRST, ORD_SAME} order_e;

    // settle rows expect {periph_full_o, periph_empty_o} in exp_data[1:0]
    typedef struct {
        op_e              op;
        order_e           order;
        afifo_pkg::addr_t addr;
        afifo_pkg::data_t data;
        afifo_pkg::resp_t exp_resp;
        afifo_pkg::data_t exp_data;
        bit               exp_pulse;
    } row_t;

    logic             clk_axi;
    logic             clk_periph;
    logic             axi_resetn_i;
    logic             axi_awvalid_i;
    logic             axi_awready_o;
    afifo_pkg::data_t axi_wdata_i;
    logic             axi_wvalid_i;
    logic             axi_wready_o;
    afifo_pkg::resp_t axi_bresp_o;
    logic             axi_bvalid_o;
    logic             axi_bready_i;
    afifo_pkg::addr_t axi_araddr_i;
    logic             axi_arvalid_i;
    logic             axi_arready_o;
    afifo_pkg::data_t axi_rdata_o;
    afifo_pkg::resp_t axi_rresp_o;
    logic             axi_rvalid_o;
    logic             axi_rready_i;
    logic             periph_rd_en_i;
    afifo_pkg::data_t periph_rdata_o;
    logic             periph_rvalid_o;
    logic             periph_empty_o;
    logic             periph_full_o;

    row_t             rows [$];
    afifo_pkg::data_t words [9];
    bit               table_built = 1'b0;
    int               check_count = 0;
    int               error_count = 0;

    axi_lite_async_fifo UUT (.*);

    // ------------------------------
    // clocks and watchdog
    // ------------------------------
    initial begin
        clk_axi = 1'b0;
        forever #(AXI_PERIOD / 2) clk_axi = ~clk_axi;
    end

    initial begin
        clk_periph = 1'b0;
        forever #(PERIPH_PERIOD / 2) clk_periph = ~clk_periph;
    end

    initial begin
        wait (table_built);
        #(rows.size() * 200 * AXI_PERIOD);
        $display("timeout: the test table did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // status word as the register map defines it
    function automatic afifo_pkg::data_t status_word(bit empty, bit full, int occ);
        afifo_pkg::data_t w;
        w = '0;
        w[afifo_pkg::STAT_EMPTY_BIT] = empty;
        w[afifo_pkg::STAT_FULL_BIT]  = full;
        w[afifo_pkg::STAT_OCC_LSB +: 4] = occ[3:0];
        return w;
    endfunction

    task automatic add_row(op_e op, order_e order, afifo_pkg::addr_t addr,
                           afifo_pkg::data_t data, afifo_pkg::resp_t exp_resp,
                           afifo_pkg::data_t exp_data, bit exp_pulse);
        row_t r;
        r.op        = op;
        r.order     = order;
        r.addr      = addr;
        r.data      = data;
        r.exp_resp  = exp_resp;
        r.exp_data  = exp_data;
        r.exp_pulse = exp_pulse;
        rows.push_back(r);
    endtask

    // ------------------------------
    // bus tasks
    // ------------------------------
    task automatic write_word(input afifo_pkg::data_t data, input order_e order,
                              output afifo_pkg::resp_t resp, output bit ok);
        order_e ord;
        bit     aw_done;
        bit     w_done;
        bit     aw_on;
        bit     w_on;
        int     cnt;
        ord = order;
        if (ord == ORD_RANDOM) begin
            ord = order_e'($urandom_range(3, 1));
        end
        aw_done = 1'b0;
        w_done  = 1'b0;
        aw_on   = (ord != ORD_W_FIRST);
        w_on    = (ord != ORD_AW_FIRST);
        cnt     = 0;
        resp    = '0;
        ok      = 1'b0;
        @(posedge clk_axi);
        axi_awvalid_i <= aw_on;
        axi_wvalid_i  <= w_on;
        axi_wdata_i   <= data;
        while (!(aw_done && w_done) && cnt < HS_LIMIT) begin
            @(posedge clk_axi);
            cnt++;
            if (axi_awvalid_i && axi_awready_o) begin
                aw_done = 1'b1;
                axi_awvalid_i <= 1'b0;
            end
            if (axi_wvalid_i && axi_wready_o) begin
                w_done = 1'b1;
                axi_wvalid_i <= 1'b0;
            end
            // second channel opens once the first one is through
            if (aw_done && !w_on) begin
                w_on = 1'b1;
                axi_wvalid_i <= 1'b1;
            end
            if (w_done && !aw_on) begin
                aw_on = 1'b1;
                axi_awvalid_i <= 1'b1;
            end
        end
        if (!(aw_done && w_done)) begin
            axi_awvalid_i <= 1'b0;
            axi_wvalid_i  <= 1'b0;
            report_error("the AW/W handshake never completed");
            return;
        end
        // B is due exactly one cycle after the later handshake
        @(posedge clk_axi);
        check_value("axi_bvalid_o", axi_bvalid_o, 1'b1);
        cnt = 0;
        while (!axi_bvalid_o && cnt < HS_LIMIT) begin
            @(posedge clk_axi);
            cnt++;
        end
        if (!axi_bvalid_o) begin
            report_error("the write response never became valid");
            return;
        end
        resp = axi_bresp_o;
        axi_bready_i <= 1'b1;
        @(posedge clk_axi);
        // still held, bready was low on the edge before
        check_value("axi_bvalid_o", axi_bvalid_o, 1'b1);
        axi_bready_i <= 1'b0;
        ok = 1'b1;
    endtask

    task automatic read_register(input afifo_pkg::addr_t addr, output afifo_pkg::data_t data,
                                 output afifo_pkg::resp_t resp, output bit ok);
        int cnt;
        cnt  = 0;
        data = '0;
        resp = '0;
        ok   = 1'b0;
        @(posedge clk_axi);
        axi_araddr_i  <= addr;
        axi_arvalid_i <= 1'b1;
        do begin
            @(posedge clk_axi);
            cnt++;
        end while (!axi_arready_o && cnt < HS_LIMIT);
        axi_arvalid_i <= 1'b0;
        if (!axi_arready_o) begin
            report_error("the AR handshake never completed");
            return;
        end
        // R follows one cycle after AR
        @(posedge clk_axi);
        if (!axi_rvalid_o) begin
            report_error("read data was not valid one cycle after AR");
            return;
        end
        data = axi_rdata_o;
        resp = axi_rresp_o;
        axi_rready_i <= 1'b1;
        @(posedge clk_axi);
        axi_rready_i <= 1'b0;
        ok = 1'b1;
    endtask

    task automatic pop_word(output bit pulse, output afifo_pkg::data_t data);
        @(posedge clk_periph);
        periph_rd_en_i <= 1'b1;
        @(posedge clk_periph);
        periph_rd_en_i <= 1'b0;
        @(posedge clk_periph);
        pulse = periph_rvalid_o;
        data  = periph_rdata_o;
        @(posedge clk_periph);
        // the pulse lasts one cycle only
        if (pulse) begin
            check_value("periph_rvalid_o", periph_rvalid_o, 1'b0);
        end
    endtask

    // ------------------------------
    // stimulus table and main loop
    // ------------------------------
    initial begin
        afifo_pkg::resp_t resp;
        afifo_pkg::data_t rdata;
        bit               ok;
        bit               pulse;
        int               errs_before;

        void'($urandom(32'h922f_5063));
        axi_resetn_i   = 1'b0;
        axi_awvalid_i  = 1'b0;
        axi_wdata_i    = '0;
        axi_wvalid_i   = 1'b0;
        axi_bready_i   = 1'b0;
        axi_araddr_i   = '0;
        axi_arvalid_i  = 1'b0;
        axi_rready_i   = 1'b0;
        periph_rd_en_i = 1'b0;
        foreach (words[i]) begin
            words[i] = $urandom();
        end

        // status after reset, then three pushes and two peeks
        add_row(OP_AXI_READ, ORD_RANDOM, afifo_pkg::ADDR_STATUS, '0,
                afifo_pkg::RESP_OKAY, status_word(1, 0, 0), 0);
        add_row(OP_SETTLE, ORD_RANDOM, '0, '0, afifo_pkg::RESP_OKAY, 32'h1, 0);
        for (int i = 0; i < 3; i++) begin
            add_row(OP_AXI_WRITE, ORD_RANDOM, '0, words[i], afifo_pkg::RESP_OKAY, '0, 0);
        end
        add_row(OP_SETTLE, ORD_RANDOM, '0, '0, afifo_pkg::RESP_OKAY, 32'h0, 0);
        add_row(OP_AXI_READ, ORD_RANDOM, afifo_pkg::ADDR_PEEK, '0,
                afifo_pkg::RESP_OKAY, words[0], 0);
        add_row(OP_AXI_READ, ORD_RANDOM, afifo_pkg::ADDR_PEEK, '0,
                afifo_pkg::RESP_OKAY, words[0], 0);
        add_row(OP_AXI_READ, ORD_RANDOM, afifo_pkg::ADDR_STATUS, '0,
                afifo_pkg::RESP_OKAY, status_word(0, 0, 3), 0);
        // both split orders, then fill up and overflow once
        add_row(OP_AXI_WRITE, ORD_AW_FIRST, '0, words[3], afifo_pkg::RESP_OKAY, '0, 0);
        add_row(OP_AXI_WRITE, ORD_W_FIRST, '0, words[4], afifo_pkg::RESP_OKAY, '0, 0);
        for (int i = 5; i < afifo_pkg::FIFO_DEPTH; i++) begin
            add_row(OP_AXI_WRITE, ORD_RANDOM, '0, words[i], afifo_pkg::RESP_OKAY, '0, 0);
        end
        add_row(OP_AXI_WRITE, ORD_RANDOM, '0, words[8], afifo_pkg::RESP_SLVERR, '0, 0);
        add_row(OP_SETTLE, ORD_RANDOM, '0, '0, afifo_pkg::RESP_OKAY, 32'h2, 0);
        add_row(OP_AXI_READ, ORD_RANDOM, afifo_pkg::ADDR_STATUS, '0,
                afifo_pkg::RESP_OKAY, status_word(0, 1, afifo_pkg::FIFO_DEPTH), 0);
        // drain in write order, then one pop into an empty fifo
        for (int i = 0; i < afifo_pkg::FIFO_DEPTH; i++) begin
            add_row(OP_PERIPH_POP, ORD_RANDOM, '0, '0, afifo_pkg::RESP_OKAY, words[i], 1);
        end
        add_row(OP_SETTLE, ORD_RANDOM, '0, '0, afifo_pkg::RESP_OKAY, 32'h1, 0);
        add_row(OP_PERIPH_POP, ORD_RANDOM, '0, '0, afifo_pkg::RESP_OKAY, '0, 0);
        add_row(OP_AXI_READ, ORD_RANDOM, afifo_pkg::ADDR_PEEK, '0,
                afifo_pkg::RESP_SLVERR, '0, 0);
        add_row(OP_AXI_READ, ORD_RANDOM, 4'h8, '0, afifo_pkg::RESP_SLVERR, '0, 0);
        table_built = 1'b1;

        repeat (4) @(posedge clk_axi);
        // handshake outputs stay low while reset is held
        check_value("reset outputs",
                    {axi_awready_o, axi_wready_o, axi_bvalid_o,
                     axi_arready_o, axi_rvalid_o, periph_rvalid_o}, '0);
        axi_resetn_i <= 1'b1;

        foreach (rows[i]) begin
            errs_before = error_count;
            case (rows[i].op)
                OP_AXI_WRITE: begin
                    write_word(rows[i].data, rows[i].order, resp, ok);
                    if (ok) begin
                        check_value("axi_bresp_o", resp, rows[i].exp_resp);
                    end
                end
                OP_AXI_READ: begin
                    read_register(rows[i].addr, rdata, resp, ok);
                    if (ok) begin
                        check_value("axi_rresp_o", resp, rows[i].exp_resp);
                        check_value("axi_rdata_o", rdata, rows[i].exp_data);
                    end
                end
                OP_PERIPH_POP: begin
                    pop_word(pulse, rdata);
                    check_value("periph_rvalid_o pulse", pulse, rows[i].exp_pulse);
                    if (pulse && rows[i].exp_pulse) begin
                        check_value("periph_rdata_o", rdata, rows[i].exp_data);
                    end
                end
                default: begin
                    // long enough for either pointer to cross
                    repeat (10) @(posedge clk_periph);
                    check_value("periph_empty_o", periph_empty_o, rows[i].exp_data[0]);
                    check_value("periph_full_o", periph_full_o, rows[i].exp_data[1]);
                end
            endcase
            $display("row %0d %s: %s", i, rows[i].op.name(),
                     (error_count == errs_before) ? "ok" : "mismatch");
        end

        $display("rows %0d, checks %0d, errors %0d", rows.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
